//--- common/ipdc_cfg.svh
`ifndef IPDC_CFG_SVH
`define IPDC_CFG_SVH

// image geometry, square image and window
`define IPDC_IMG_DIM      8
`define IPDC_WIN_DIM      4
`define IPDC_PIX_CNT      64
`define IPDC_WIN_CNT      16

// origin index for zoom-in, row 2 col 2
`define IPDC_ZOOM_ORIGIN  18

// one color channel
`define IPDC_CHAN_W       8

// chroma offset, 128 scaled by 8 before the final shift
`define IPDC_CBCR_BIAS    1024

`endif

//--- common/ipdc_pkg.sv
`include "ipdc_cfg.svh"

package ipdc_pkg;

	// pixel types
	typedef logic [`IPDC_CHAN_W-1:0]   chan_t;
	typedef logic [3*`IPDC_CHAN_W-1:0] pixel_t;

	// red sits in the low byte
	typedef struct packed {
		chan_t b;
		chan_t g;
		chan_t r;
	} rgb_s;

	// index and counter widths
	typedef logic [$clog2(`IPDC_PIX_CNT)-1:0]   pix_idx_t;
	typedef logic [$clog2(`IPDC_WIN_CNT+1)-1:0] win_cnt_t;

	// op codes as seen on i_op_mode
	typedef enum logic [2:0] {
		OP_LOAD   = 3'd0,
		OP_RIGHT  = 3'd1,
		OP_DOWN   = 3'd2,
		OP_HOME   = 3'd3,
		OP_ZOOM   = 3'd4,
		OP_MEDIAN = 3'd5,
		OP_YCBCR  = 3'd6,
		OP_RGB    = 3'd7
	} op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_LOAD_DONE,
		ST_DISPLAY
	} ctrl_state_e;

	// buffer write port bundle
	typedef struct packed {
		logic     we;
		pix_idx_t addr;
		pixel_t   data;
	} buf_wr_s;

endpackage

//--- source/ipdc_ctrl.sv
`timescale 1ns/1ps
`include "ipdc_cfg.svh"

module ipdc_ctrl
	import ipdc_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_op_valid,
	input  op_e      i_op_mode,
	input  logic     i_in_valid,
	input  pixel_t   i_in_data,
	output logic     o_in_ready,
	output buf_wr_s  o_wr,
	output pix_idx_t o_rd_idx,
	output logic     o_win_vld,
	output logic     o_load_done,
	output logic     o_ycbcr_mode
);

	ctrl_state_e state;
	pix_idx_t    origin;
	pix_idx_t    origin_nxt;
	pix_idx_t    load_idx;
	logic        load_seen;
	win_cnt_t    cnt;
	pix_idx_t    win_off;

	// --------------------------------------------------
	// origin update
	// --------------------------------------------------
	// col in low 3 bits, row in high 3 bits
	always_comb begin
		origin_nxt = origin;
		case (i_op_mode)
			OP_RIGHT: begin
				// stop once the window touches the right edge
				if (origin[2:0] < 3'(`IPDC_IMG_DIM - `IPDC_WIN_DIM)) begin
					origin_nxt = origin + 6'd1;
				end
			end
			OP_DOWN: begin
				if (origin[5:3] < 3'(`IPDC_IMG_DIM - `IPDC_WIN_DIM)) begin
					origin_nxt = origin + 6'(`IPDC_IMG_DIM);
				end
			end
			OP_HOME: origin_nxt = '0;
			OP_ZOOM: origin_nxt = 6'(`IPDC_ZOOM_ORIGIN);
			default: origin_nxt = origin;
		endcase
	end

	// --------------------------------------------------
	// main fsm
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= ST_IDLE;
			origin       <= '0;
			load_idx     <= '0;
			load_seen    <= 1'b0;
			cnt          <= '0;
			o_win_vld    <= 1'b0;
			o_ycbcr_mode <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_op_valid) begin
						origin <= origin_nxt;
						case (i_op_mode)
							OP_LOAD: begin
								state     <= ST_LOAD;
								load_idx  <= '0;
								load_seen <= 1'b0;
							end
							OP_RIGHT, OP_DOWN, OP_HOME, OP_ZOOM: begin
								state <= ST_DISPLAY;
								cnt   <= '0;
							end
							OP_YCBCR: o_ycbcr_mode <= 1'b1;
							OP_RGB:   o_ycbcr_mode <= 1'b0;
							// median is a no-op, stays idle
							default:  state <= ST_IDLE;
						endcase
					end
				end
				ST_LOAD: begin
					// raster order, one pixel per valid cycle
					if (i_in_valid) begin
						load_idx  <= load_idx + 6'd1;
						load_seen <= 1'b1;
					end else if (load_seen) begin
						state <= ST_LOAD_DONE;
					end
				end
				// single cycle, formatter emits the done beat
				ST_LOAD_DONE: state <= ST_IDLE;
				ST_DISPLAY: begin
					if (cnt == win_cnt_t'(`IPDC_WIN_CNT)) begin
						state     <= ST_IDLE;
						cnt       <= '0;
						o_win_vld <= 1'b0;
					end else begin
						o_win_vld <= 1'b1;
						cnt       <= cnt + 5'd1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// window read address
	// --------------------------------------------------
	// cnt/4 picks the row, cnt%4 the column
	assign win_off = {1'b0, cnt[3:2], 1'b0, cnt[1:0]};

	// issued together with o_win_vld
	always_ff @(posedge i_clk) begin
		o_rd_idx <= origin + win_off;
	end

	// buffer write port
	always_comb begin
		o_wr.we   = (state == ST_LOAD) && i_in_valid;
		o_wr.addr = load_idx;
		o_wr.data = i_in_data;
	end

	assign o_in_ready  = (state == ST_IDLE) || (state == ST_LOAD);
	assign o_load_done = (state == ST_LOAD_DONE);

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// walk never runs past the window
	a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		cnt <= win_cnt_t'(`IPDC_WIN_CNT));

	// window never hangs off the image
	a_origin_in_bounds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		origin[2:0] <= 3'(`IPDC_IMG_DIM - `IPDC_WIN_DIM) &&
		origin[5:3] <= 3'(`IPDC_IMG_DIM - `IPDC_WIN_DIM));

endmodule

//--- source/image_buffer.sv
`timescale 1ns/1ps
`include "ipdc_cfg.svh"

module image_buffer
	import ipdc_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  buf_wr_s  i_wr,
	input  pix_idx_t i_rd_idx,
	output pixel_t   o_rd_data
);

	// 64 pixels, raster order
	pixel_t mem [`IPDC_PIX_CNT];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	// image starts black after reset
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `IPDC_PIX_CNT; i++) begin
				mem[i] <= '0;
			end
		end else if (i_wr.we) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------
	// zero latency, formatter registers it
	assign o_rd_data = mem[i_rd_idx];

endmodule

//--- source/pixel_formatter.sv
`timescale 1ns/1ps
`include "ipdc_cfg.svh"

module pixel_formatter
	import ipdc_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  pixel_t i_pix,
	input  logic   i_win_vld,
	input  logic   i_load_done,
	input  logic   i_ycbcr_mode,
	output logic   o_out_valid,
	output pixel_t o_out_data
);

	rgb_s        rgb;
	rgb_s        ycc;
	logic [11:0] r_x;
	logic [11:0] g_x;
	logic [11:0] b_x;
	logic [11:0] y_sum;
	logic [11:0] cb_sum;
	logic [11:0] cr_sum;

	// drop 3 fraction bits, clip at 255
	function automatic chan_t sat_div8(input logic [11:0] sum);
		logic [8:0] q;
		q = sum[11:3];
		if (q[8]) begin
			return {`IPDC_CHAN_W{1'b1}};
		end
		return q[7:0];
	endfunction

	assign rgb = rgb_s'(i_pix);

	// zero-extended channels
	assign r_x = {4'b0, rgb.r};
	assign g_x = {4'b0, rgb.g};
	assign b_x = {4'b0, rgb.b};

	// --------------------------------------------------
	// ycbcr, all sums scaled by 8
	// --------------------------------------------------
	// y = (2r + 5g + 4) / 8, max 1789
	assign y_sum = (r_x << 1) + (g_x << 2) + g_x + 12'd4;

	// bias first so the sum never goes negative
	// cb = (1024 + 4b - r - 2g + 4) / 8
	assign cb_sum = 12'(`IPDC_CBCR_BIAS) + 12'd4 + (b_x << 2) - r_x - (g_x << 1);

	// cr = (1024 + 4r - 3g - b + 4) / 8
	assign cr_sum = 12'(`IPDC_CBCR_BIAS) + 12'd4 + (r_x << 2) - (g_x << 1) - g_x - b_x;

	// y low byte, cb middle, cr high
	always_comb begin
		ycc.r = sat_div8(y_sum);
		ycc.g = sat_div8(cb_sum);
		ycc.b = sat_div8(cr_sum);
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_out_data  <= '0;
		end else if (i_load_done) begin
			// load finished, one zero beat
			o_out_valid <= 1'b1;
			o_out_data  <= '0;
		end else if (i_win_vld) begin
			o_out_valid <= 1'b1;
			o_out_data  <= i_ycbcr_mode ? pixel_t'(ycc) : i_pix;
		end else begin
			o_out_valid <= 1'b0;
		end
	end

	// load done and window walk come from different fsm states
	a_done_vs_win: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_load_done && i_win_vld));

endmodule

//--- source/ipdc_top.sv
`timescale 1ns/1ps

module ipdc_top
	import ipdc_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_op_valid,
	input  logic [2:0] i_op_mode,
	input  logic       i_in_valid,
	input  pixel_t     i_in_data,
	output logic       o_in_ready,
	output logic       o_out_valid,
	output pixel_t     o_out_data
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	buf_wr_s  buf_wr;
	pix_idx_t rd_idx;
	pixel_t   rd_pix;
	logic     win_vld;
	logic     load_done;
	logic     ycbcr_mode;

	// control, op decode and window walk
	ipdc_ctrl u_ctrl (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_op_valid   (i_op_valid),
		.i_op_mode    (op_e'(i_op_mode)),
		.i_in_valid   (i_in_valid),
		.i_in_data    (i_in_data),
		.o_in_ready   (o_in_ready),
		.o_wr         (buf_wr),
		.o_rd_idx     (rd_idx),
		.o_win_vld    (win_vld),
		.o_load_done  (load_done),
		.o_ycbcr_mode (ycbcr_mode)
	);

	// 8x8 image storage
	image_buffer u_buf (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr      (buf_wr),
		.i_rd_idx  (rd_idx),
		.o_rd_data (rd_pix)
	);

	// color conversion and output register
	pixel_formatter u_fmt (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_pix        (rd_pix),
		.i_win_vld    (win_vld),
		.i_load_done  (load_done),
		.i_ycbcr_mode (ycbcr_mode),
		.o_out_valid  (o_out_valid),
		.o_out_data   (o_out_data)
	);

endmodule

//--- tb/tb_ipdc.sv
`timescale 1ns/1ps

module tb_ipdc
	import ipdc_pkg::*;
();

	logic       i_clk = 1'b0;
	logic       i_rst_n;
	logic       i_op_valid;
	logic [2:0] i_op_mode;
	logic       i_in_valid;
	pixel_t     i_in_data;
	logic       o_in_ready;
	logic       o_out_valid;
	pixel_t     o_out_data;

	// golden file handle, image and one expected window
	int     fd;
	pixel_t image [64];
	pixel_t expect_win [16];

	// 4 ns period
	always #2 i_clk = ~i_clk;

	ipdc_top dut0 (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [23:0] actual,
			input logic [23:0] expected);
		if (actual !== expected) begin
			stop_on_error($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	// inputs change 1 ns after the edge, outputs are stable there
	task automatic next_cycle();
		@(posedge i_clk);
		#1;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (o_in_ready !== 1'b1) begin
			if (n == 200) begin
				stop_on_error("o_in_ready never went high within 200 cycles");
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_out_valid();
		int n;
		n = 0;
		while (o_out_valid !== 1'b1) begin
			if (n == 200) begin
				stop_on_error("o_out_valid never went high within 200 cycles");
			end
			next_cycle();
			n++;
		end
	endtask

	// next hex token, lines starting with # are skipped
	task automatic next_token(output bit ok, output logic [23:0] val);
		string tok;
		string rest;
		int    code;
		ok   = 1'b0;
		val  = '0;
		code = $fscanf(fd, "%s", tok);
		while (code == 1 && tok.substr(0, 0) == "#") begin
			code = $fgets(rest, fd);
			code = $fscanf(fd, "%s", tok);
		end
		if (code == 1) begin
			code = $sscanf(tok, "%h", val);
			ok   = (code == 1);
		end
	endtask

	// one cycle op strobe, only when idle
	task automatic send_op(input logic [2:0] op);
		wait_ready();
		i_op_valid = 1'b1;
		i_op_mode  = op;
		next_cycle();
		i_op_valid = 1'b0;
	endtask

	// --------------------------------------------------
	// op sequences
	// --------------------------------------------------
	task automatic load_image();
		send_op(3'd0);
		// raster order, one pixel per cycle
		for (int i = 0; i < 64; i++) begin
			i_in_valid = 1'b1;
			i_in_data  = image[i];
			next_cycle();
		end
		i_in_valid = 1'b0;
		i_in_data  = '0;
		// single zero beat marks the end of the load
		wait_out_valid();
		check_value("o_out_data", o_out_data, 24'h0);
		next_cycle();
		check_value("o_out_valid", o_out_valid, 24'h0);
	endtask

	task automatic check_window();
		wait_out_valid();
		// 16 back to back beats, no gaps
		for (int i = 0; i < 16; i++) begin
			check_value("o_out_valid", o_out_valid, 24'h1);
			check_value("o_out_data", o_out_data, expect_win[i]);
			next_cycle();
		end
		check_value("o_out_valid", o_out_valid, 24'h0);
	endtask

	// mode ops and median stay silent
	task automatic check_quiet();
		for (int i = 0; i < 20; i++) begin
			check_value("o_out_valid", o_out_valid, 24'h0);
			next_cycle();
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		logic [23:0] tok;
		logic [2:0]  op;
		bit          ok;
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = 3'd0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		fd = $fopen("tb/ipdc_golden.txt", "r");
		if (fd == 0) begin
			stop_on_error("could not open tb/ipdc_golden.txt");
		end
		for (int i = 0; i < 64; i++) begin
			next_token(ok, tok);
			if (!ok) begin
				stop_on_error("golden file ends before all 64 image pixels");
			end
			image[i] = tok;
		end
		repeat (16) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		check_value("o_out_valid", o_out_valid, 24'h0);
		check_value("o_out_data", o_out_data, 24'h0);
		check_value("o_in_ready", o_in_ready, 24'h1);
		next_token(ok, tok);
		while (ok) begin
			op = tok[2:0];
			if (op == 3'd0) begin
				load_image();
			end else if (op <= 3'd4) begin
				// display op carries its expected window
				for (int i = 0; i < 16; i++) begin
					next_token(ok, tok);
					if (!ok) begin
						stop_on_error("golden file ends inside an expected window");
					end
					expect_win[i] = tok;
				end
				send_op(op);
				check_value("o_in_ready", o_in_ready, 24'h0);
				check_window();
			end else begin
				send_op(op);
				check_quiet();
			end
			next_token(ok, tok);
		end
		$fclose(fd);
		$display("sim passed");
		$finish;
	end

endmodule

//--- tb/ipdc_golden.txt
# image: 64 pixels bbggrr in raster order, red in the low byte
# ops: op code, then 16 expected window pixels for ops 1 to 4
0000ff ff0000 844202 864303 884404 8a4505 8c4606 8e4707
904808 924909 944a0a 964b0b 984c0c 9a4d0d 9c4e0e 9e4f0f
a05010 a25111 a45212 a65313 a85414 aa5515 ac5616 ae5717
b05818 b25919 b45a1a b65b1b b85c1c ba5d1d bc5e1e be5f1f
c06020 c26121 c46222 c66323 c86424 ca6525 cc6626 ce6727
d06828 d26929 d46a2a d66b2b d86c2c da6d2d dc6e2e de6f2f
e07030 e27131 e47232 e67333 e87434 ea7535 ec7636 ee7737
f07838 f27939 f47a3a f67b3b f87c3c fa7d3d fc7e3e fe7f3f
0
4 a45212 a65313 a85414 aa5515 b45a1a b65b1b b85c1c ba5d1d
  c46222 c66323 c86424 ca6525 d46a2a d66b2b d86c2c da6d2d
1 a65313 a85414 aa5515 ac5616 b65b1b b85c1c ba5d1d bc5e1e
  c66323 c86424 ca6525 cc6626 d66b2b d86c2c da6d2d dc6e2e
1 a85414 aa5515 ac5616 ae5717 b85c1c ba5d1d bc5e1e be5f1f
  c86424 ca6525 cc6626 ce6727 d86c2c da6d2d dc6e2e de6f2f
1 a85414 aa5515 ac5616 ae5717 b85c1c ba5d1d bc5e1e be5f1f
  c86424 ca6525 cc6626 ce6727 d86c2c da6d2d dc6e2e de6f2f
2 b85c1c ba5d1d bc5e1e be5f1f c86424 ca6525 cc6626 ce6727
  d86c2c da6d2d dc6e2e de6f2f e87434 ea7535 ec7636 ee7737
2 c86424 ca6525 cc6626 ce6727 d86c2c da6d2d dc6e2e de6f2f
  e87434 ea7535 ec7636 ee7737 f87c3c fa7d3d fc7e3e fe7f3f
2 c86424 ca6525 cc6626 ce6727 d86c2c da6d2d dc6e2e de6f2f
  e87434 ea7535 ec7636 ee7737 f87c3c fa7d3d fc7e3e fe7f3f
6
3 ff6040 60ff00 58b12a 58b22b 57b52f 57b630 57b631 57b732
  56ba36 56bb37 56bb38 56bc39 55bf3d 55c03e 55c03f 55c140
7
5
3 0000ff ff0000 844202 864303 904808 924909 944a0a 964b0b
  a05010 a25111 a45212 a65313 b05818 b25919 b45a1a b65b1b

//--- compile.f
+incdir+common
common/ipdc_pkg.sv
source/ipdc_ctrl.sv
source/image_buffer.sv
source/pixel_formatter.sv
source/ipdc_top.sv
tb/tb_ipdc.sv

//--- Bender.yml
package:
  name: ipdc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ipdc_pkg.sv
      - source/ipdc_ctrl.sv
      - source/image_buffer.sv
      - source/pixel_formatter.sv
      - source/ipdc_top.sv
  - target: test
    files:
      - tb/tb_ipdc.sv
